// ==== ifu_fetch.f ====
hw/ifu_pkg.sv
hw/fetch_controller.sv
hw/fetch_regs.sv
hw/decode_stage.sv
hw/ifu_top.sv
sim/imem_model.sv
sim/ifu_tb.sv

// ==== Bender.yml ====
package:
  name: ifu_fetch

sources:
  - hw/ifu_pkg.sv
  - hw/fetch_controller.sv
  - hw/fetch_regs.sv
  - hw/decode_stage.sv
  - hw/ifu_top.sv
  - target: simulation
    files:
      - sim/imem_model.sv
      - sim/ifu_tb.sv

// ==== sim/ifu_tb.sv ====
`timescale 1ns/1ns

module ifu_tb;

  // retires per test, the run limit follows from their sum
  localparam int N_RESET    = 4;
  localparam int N_SEQ      = 12;
  localparam int N_JAL      = 10;
  localparam int N_BP       = 20;
  localparam int N_LAT      = 24;
  localparam int N_TOTAL    = N_RESET + N_SEQ + N_JAL + N_BP + N_LAT;
  localparam int MAX_CYCLES = 8 * (N_TOTAL + 4) * 4;

  logic                clock;
  logic                reset;
  logic                start;
  logic                arvalid;
  logic                arready;
  ifu_pkg::addr_t      araddr;
  logic                rvalid;
  logic                rready;
  ifu_pkg::inst_t      rdata;
  logic                retire_valid;
  logic                retire_ready;
  ifu_pkg::fetch_pkt_t retire_pkt;
  logic [31:0]         rng;
  int                  cycles;
  // byte offset of the jal placed at each word, 0 for filler
  int                  jump_off [0:255];
  // protocol monitor state
  logic                outstanding;
  logic                ar_waiting;
  ifu_pkg::addr_t      held_addr;
  ifu_pkg::addr_t      fetch_pc;

  ifu_top u_dut (
    .clock          (clock),
    .reset          (reset),
    .start_i        (start),
    .arvalid_o      (arvalid),
    .arready_i      (arready),
    .araddr_o       (araddr),
    .rvalid_i       (rvalid),
    .rready_o       (rready),
    .rdata_i        (rdata),
    .retire_valid_o (retire_valid),
    .retire_ready_i (retire_ready),
    .retire_pkt_o   (retire_pkt)
  );

  imem_model u_mem (
    .clock     (clock),
    .reset     (reset),
    .arvalid_i (arvalid),
    .arready_o (arready),
    .araddr_i  (araddr),
    .rvalid_o  (rvalid),
    .rready_i  (rready),
    .rdata_o   (rdata)
  );

  always #50 clock = ~clock;

  // ------------------------------------------------------------
  // helpers and reference model
  // ------------------------------------------------------------
  task automatic stop_with_failure(input string reason);
    $display("%s", reason);
    $display("ERRORS FOUND");
    $fatal(1, "simulation stopped");
  endtask

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] expected);
    if (got !== expected) begin
      stop_with_failure($sformatf("FAIL at %0t: %s got %h expected %h",
                                  $time, name, got, expected));
    end
  endtask

  function automatic logic [31:0] lcg_next();
    rng = rng * 32'd1664525 + 32'd1013904223;
    return rng;
  endfunction

  function automatic ifu_pkg::inst_t mem_word(input ifu_pkg::addr_t addr);
    return u_mem.mem[addr[9:2]];
  endfunction

  // non-jal filler, every address bit feeds the word
  function automatic ifu_pkg::inst_t filler_word(input ifu_pkg::addr_t addr);
    return {addr[24:0] ^ addr[31:7], 7'h13};
  endfunction

  // jal x1 with a byte offset
  function automatic ifu_pkg::inst_t jal_word(input int offset);
    logic [20:0] off;
    off = offset[20:0];
    return {off[20], off[10:1], off[11], off[19:12], 5'd1, 7'h6f};
  endfunction

  // next pc is +4, or pc plus the offset the jal was built with
  function automatic ifu_pkg::addr_t next_pc(input ifu_pkg::addr_t pc);
    if (jump_off[pc[9:2]] == 0) return pc + 32'd4;
    return pc + jump_off[pc[9:2]];
  endfunction

  // jal at a word index, offset kept for the model
  task automatic place_jal(input int idx, input int offset);
    u_mem.mem[idx] = jal_word(offset);
    jump_off[idx]  = offset;
  endtask

  // jumps 0x04 -> 0x24, 0x28 -> 0x10, 0x18 -> 0x58, 0x70 -> 0x10
  task automatic load_program(input bit with_jal);
    int i;
    for (i = 0; i < 256; i++) begin
      u_mem.mem[i] = filler_word(ifu_pkg::addr_t'(i) << 2);
      jump_off[i]  = 0;
    end
    if (with_jal) begin
      place_jal(1, 32);
      place_jal(10, -24);
      place_jal(6, 64);
      place_jal(28, -96);
    end
  endtask

  // memory reloaded while reset holds the DUT
  task automatic apply_reset(input bit with_jal);
    @(posedge clock);
    #10;
    reset        = 1'b1;
    start        = 1'b0;
    retire_ready = 1'b0;
    load_program(with_jal);
    repeat (5) @(posedge clock);
    #10;
    reset = 1'b0;
  endtask

  // start, then compare each retire against the walked program
  task automatic retire_and_compare(input int count, input bit stall);
    ifu_pkg::addr_t exp_pc;
    ifu_pkg::inst_t exp_inst;
    logic [31:0]    r;
    int             got;
    exp_pc       = ifu_pkg::RESET_PC;
    got          = 0;
    start        = 1'b1;
    retire_ready = 1'b1;
    while (got < count) begin
      @(negedge clock);
      if (retire_valid && retire_ready) begin
        exp_inst = mem_word(exp_pc);
        check_value("retire_pkt_o.pc", retire_pkt.pc, exp_pc);
        check_value("retire_pkt_o.inst", retire_pkt.inst, exp_inst);
        exp_pc = next_pc(exp_pc);
        got++;
      end
      @(posedge clock);
      #10;
      start        = 1'b0;
      r            = lcg_next();
      retire_ready = stall ? r[31] : 1'b1;
    end
  endtask

  // ------------------------------------------------------------
  // directed tests
  // ------------------------------------------------------------
  task automatic reset_state_test();
    apply_reset(1'b0);
    repeat (3) begin
      @(negedge clock);
      check_value("arvalid_o", arvalid, 1'b0);
      check_value("rready_o", rready, 1'b0);
      check_value("retire_valid_o", retire_valid, 1'b0);
    end
    @(posedge clock);
    #10;
    retire_and_compare(N_RESET, 1'b0);
  endtask

  task automatic sequential_fetch_test();
    apply_reset(1'b0);
    retire_and_compare(N_SEQ, 1'b0);
  endtask

  task automatic jal_redirect_test();
    apply_reset(1'b1);
    retire_and_compare(N_JAL, 1'b0);
  endtask

  task automatic backpressure_test();
    apply_reset(1'b1);
    retire_and_compare(N_BP, 1'b1);
  endtask

  // random memory delays plus stalls, monitor does the work
  task automatic latency_test();
    apply_reset(1'b0);
    retire_and_compare(N_LAT, 1'b1);
  endtask

  // ------------------------------------------------------------
  // read channel monitor, values settle before the falling edge
  // ------------------------------------------------------------
  always @(negedge clock) begin
    if (reset) begin
      outstanding = 1'b0;
      ar_waiting  = 1'b0;
      fetch_pc    = ifu_pkg::RESET_PC;
    end else begin
      check_value("arvalid_o and rready_o", arvalid && rready, 1'b0);
      if (ar_waiting) begin
        check_value("arvalid_o", arvalid, 1'b1);
        check_value("araddr_o", araddr, held_addr);
      end
      if (rvalid && rready) outstanding = 1'b0;
      if (arvalid && arready) begin
        check_value("reads outstanding", outstanding, 1'b0);
        // words behind a jal never show up here
        check_value("araddr_o", araddr, fetch_pc);
        fetch_pc    = next_pc(fetch_pc);
        outstanding = 1'b1;
      end
      ar_waiting = arvalid && !arready;
      held_addr  = araddr;
    end
  end

  always @(posedge clock) begin
    cycles++;
    if (cycles > MAX_CYCLES) begin
      stop_with_failure($sformatf("timeout: no end of tests after %0d cycles", cycles));
    end
  end

  initial begin
    clock        = 1'b0;
    reset        = 1'b1;
    start        = 1'b0;
    retire_ready = 1'b0;
    rng          = 32'h8a3ede13;
    cycles       = 0;
    reset_state_test();
    sequential_fetch_test();
    jal_redirect_test();
    backpressure_test();
    latency_test();
    $display("NO ERRORS");
    $finish;
  end

endmodule

// ==== sim/imem_model.sv ====
`timescale 1ns/1ns

module imem_model (
  input  logic           clock,
  input  logic           reset,
  input  logic           arvalid_i,
  output logic           arready_o,
  input  ifu_pkg::addr_t araddr_i,
  output logic           rvalid_o,
  input  logic           rready_i,
  output ifu_pkg::inst_t rdata_o
);

  // 256 words, indexed by byte address bits [9:2]
  ifu_pkg::inst_t mem [0:255];

  logic [31:0]    lcg_state;
  logic           pending;
  ifu_pkg::addr_t addr_q;
  int unsigned    ar_wait;
  int unsigned    r_wait;
  logic           ar_fire;
  logic           r_fire;
  logic           arready_d;
  logic           rvalid_d;
  ifu_pkg::inst_t rdata_d;

  // 0..3 idle cycles before each ready or valid
  function automatic int unsigned next_delay();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state[31:30];
  endfunction

  // ------------------------------------------------------------
  // decide at the falling edge, drive 10 ns after the rising one
  // ------------------------------------------------------------
  initial begin
    lcg_state = 32'h8a3ede13;
    pending   = 1'b0;
    addr_q    = '0;
    ar_wait   = 0;
    r_wait    = 0;
    arready_o = 1'b0;
    rvalid_o  = 1'b0;
    rdata_o   = '0;
    forever begin
      @(negedge clock);
      ar_fire   = arvalid_i && arready_o;
      r_fire    = rvalid_o && rready_i;
      arready_d = arready_o;
      rvalid_d  = rvalid_o;
      rdata_d   = rdata_o;
      if (reset) begin
        pending   = 1'b0;
        arready_d = 1'b0;
        rvalid_d  = 1'b0;
        ar_wait   = next_delay();
      end else begin
        // address taken at the coming edge
        // ready even with a read in flight, so a second request would be seen
        if (ar_fire) begin
          pending   = 1'b1;
          addr_q    = araddr_i;
          arready_d = 1'b0;
          r_wait    = next_delay();
        end else if (arvalid_i) begin
          if (ar_wait == 0) arready_d = 1'b1;
          else ar_wait--;
        end
        // data beat, one read at a time
        if (r_fire) begin
          pending  = 1'b0;
          rvalid_d = 1'b0;
          ar_wait  = next_delay();
        end else if (pending && !rvalid_o && !ar_fire) begin
          if (r_wait == 0) begin
            rvalid_d = 1'b1;
            rdata_d  = mem[addr_q[9:2]];
          end else begin
            r_wait--;
          end
        end
      end
      @(posedge clock);
      #10;
      arready_o = arready_d;
      rvalid_o  = rvalid_d;
      rdata_o   = rdata_d;
    end
  end

endmodule

// ==== hw/ifu_top.sv ====
`timescale 1ns/1ns

module ifu_top (
  input  logic                clock,
  input  logic                reset,
  input  logic                start_i,

  // read address channel
  output logic                arvalid_o,
  input  logic                arready_i,
  output ifu_pkg::addr_t      araddr_o,

  // read data channel
  input  logic                rvalid_i,
  output logic                rready_o,
  input  ifu_pkg::inst_t      rdata_i,

  // retire port
  output logic                retire_valid_o,
  input  logic                retire_ready_i,
  output ifu_pkg::fetch_pkt_t retire_pkt_o
);

  // fetch <-> decode handoff
  logic                valid_post;
  logic                ready_post;
  ifu_pkg::fetch_pkt_t fetch_pkt;

  // decode -> fetch
  ifu_pkg::redirect_t  redirect;

  // controller <-> regs
  logic                pc_we;
  logic                inst_we;
  logic                branch_inst;

  // ------------------------------------------------------------
  // producer, controller plus registers
  // ------------------------------------------------------------

  fetch_controller u_fetch_controller (
    .clock            (clock),
    .reset            (reset),
    .start_i          (start_i),
    .arready_i        (arready_i),
    .arvalid_o        (arvalid_o),
    .rvalid_i         (rvalid_i),
    .rready_o         (rready_o),
    .valid_post_o     (valid_post),
    .ready_post_i     (ready_post),
    .branch_inst_i    (branch_inst),
    .redirect_valid_i (redirect.valid),
    .pc_we_o          (pc_we),
    .inst_we_o        (inst_we)
  );

  fetch_regs u_fetch_regs (
    .clock         (clock),
    .reset         (reset),
    .pc_we_i       (pc_we),
    .inst_we_i     (inst_we),
    .rdata_i       (rdata_i),
    .redirect_i    (redirect),
    .araddr_o      (araddr_o),
    .fetch_pkt_o   (fetch_pkt),
    .branch_inst_o (branch_inst)
  );

  // consumer
  decode_stage u_decode_stage (
    .clock          (clock),
    .reset          (reset),
    .valid_post_i   (valid_post),
    .ready_post_o   (ready_post),
    .fetch_pkt_i    (fetch_pkt),
    .redirect_o     (redirect),
    .retire_valid_o (retire_valid_o),
    .retire_ready_i (retire_ready_i),
    .retire_pkt_o   (retire_pkt_o)
  );

endmodule

// ==== hw/decode_stage.sv ====
`timescale 1ns/1ns

module decode_stage (
  input  logic                clock,
  input  logic                reset,

  // handoff from fetch
  input  logic                valid_post_i,
  output logic                ready_post_o,
  input  ifu_pkg::fetch_pkt_t fetch_pkt_i,

  // jal answer to fetch
  output ifu_pkg::redirect_t  redirect_o,

  // retire port
  output logic                retire_valid_o,
  input  logic                retire_ready_i,
  output ifu_pkg::fetch_pkt_t retire_pkt_o
);

  logic                entry_valid_q;
  ifu_pkg::fetch_pkt_t entry_pkt_q;
  logic                accept;
  ifu_pkg::opcode_t    pkt_opc;
  logic                pkt_is_jal;
  ifu_pkg::addr_t      jal_imm;
  logic                redir_valid_q;
  ifu_pkg::addr_t      redir_target_q;

  // ------------------------------------------------------------
  // one-entry retire buffer
  // ------------------------------------------------------------

  // room when empty, or when the held entry leaves this cycle
  assign ready_post_o = !entry_valid_q || retire_ready_i;
  assign accept       = valid_post_i && ready_post_o;

  // occupancy
  always_ff @(posedge clock) begin
    if (reset) begin
      entry_valid_q <= 1'b0;
    end else if (accept) begin
      entry_valid_q <= 1'b1;
    end else if (retire_ready_i) begin
      entry_valid_q <= 1'b0;
    end
  end

  // payload, no reset
  always_ff @(posedge clock) begin
    if (accept) begin
      entry_pkt_q <= fetch_pkt_i;
    end
  end

  assign retire_valid_o = entry_valid_q;
  assign retire_pkt_o   = entry_pkt_q;

  // ------------------------------------------------------------
  // jal target
  // ------------------------------------------------------------

  assign pkt_opc    = fetch_pkt_i.inst[6:0];
  assign pkt_is_jal = (pkt_opc == ifu_pkg::OPC_JAL);

  // j-type immediate, imm[20|10:1|11|19:12], bit 0 always zero
  assign jal_imm = {{11{fetch_pkt_i.inst[31]}},
                    fetch_pkt_i.inst[31],
                    fetch_pkt_i.inst[19:12],
                    fetch_pkt_i.inst[20],
                    fetch_pkt_i.inst[30:21],
                    1'b0};

  // pulse one cycle after the jal handoff
  always_ff @(posedge clock) begin
    if (reset) begin
      redir_valid_q <= 1'b0;
    end else begin
      redir_valid_q <= accept && pkt_is_jal;
    end
  end

  // target only sampled on a jal accept
  always_ff @(posedge clock) begin
    if (accept && pkt_is_jal) begin
      redir_target_q <= fetch_pkt_i.pc + jal_imm;
    end
  end

  assign redirect_o.valid  = redir_valid_q;
  assign redirect_o.target = redir_target_q;

  // ------------------------------------------------------------
  // checks
  // ------------------------------------------------------------

  // stalled retire keeps its entry untouched
  a_retire_hold: assert property (@(posedge clock) disable iff (reset)
    retire_valid_o && !retire_ready_i |=> retire_valid_o && $stable(retire_pkt_o));

endmodule

// ==== hw/fetch_regs.sv ====
`timescale 1ns/1ns

module fetch_regs (
  input  logic                clock,
  input  logic                reset,

  // strobes from the controller
  input  logic                pc_we_i,
  input  logic                inst_we_i,

  // read data from memory
  input  ifu_pkg::inst_t      rdata_i,

  // jal target from decode
  input  ifu_pkg::redirect_t  redirect_i,

  output ifu_pkg::addr_t      araddr_o,
  output ifu_pkg::fetch_pkt_t fetch_pkt_o,
  output logic                branch_inst_o
);

  ifu_pkg::addr_t   pc_q;
  ifu_pkg::inst_t   inst_q;
  ifu_pkg::opcode_t held_opc;

  // ------------------------------------------------------------
  // pc register
  // ------------------------------------------------------------

  // redirect wins, else step past a non-jal at handoff
  // a jal leaves pc alone until its target arrives
  always_ff @(posedge clock) begin
    if (reset) begin
      pc_q <= ifu_pkg::RESET_PC;
    end else if (redirect_i.valid) begin
      pc_q <= redirect_i.target;
    end else if (pc_we_i && !branch_inst_o) begin
      pc_q <= pc_q + ifu_pkg::PC_STEP;
    end
  end

  // ------------------------------------------------------------
  // instruction register
  // ------------------------------------------------------------

  // loaded on the r beat only
  always_ff @(posedge clock) begin
    if (inst_we_i) begin
      inst_q <= rdata_i;
    end
  end

  // jal predetect, spares the controller any decoding
  assign held_opc      = inst_q[6:0];
  assign branch_inst_o = (held_opc == ifu_pkg::OPC_JAL);

  // pc drives the bus and tags the handed-off word
  assign araddr_o         = pc_q;
  assign fetch_pkt_o.pc   = pc_q;
  assign fetch_pkt_o.inst = inst_q;

  // ------------------------------------------------------------
  // checks
  // ------------------------------------------------------------

  // redirect lands while the controller waits in wait_branch,
  // never on a handoff cycle
  a_we_redir_excl: assert property (@(posedge clock) disable iff (reset)
    !(pc_we_i && redirect_i.valid));

endmodule

// ==== hw/fetch_controller.sv ====
`timescale 1ns/1ns

module fetch_controller (
  input  logic clock,
  input  logic reset,
  input  logic start_i,

  // read address channel
  input  logic arready_i,
  output logic arvalid_o,

  // read data channel
  input  logic rvalid_i,
  output logic rready_o,

  // handoff to decode
  output logic valid_post_o,
  input  logic ready_post_i,

  // held word is a jal, from fetch_regs
  input  logic branch_inst_i,
  // target pulse back from decode
  input  logic redirect_valid_i,

  // write strobes into fetch_regs
  output logic pc_we_o,
  output logic inst_we_o
);

  ifu_pkg::fetch_state_t state_q;
  ifu_pkg::fetch_state_t state_d;

  // ------------------------------------------------------------
  // outputs, decoded straight from the state
  // ------------------------------------------------------------

  assign arvalid_o    = (state_q == ifu_pkg::wait_arready);
  assign rready_o     = (state_q == ifu_pkg::wait_rvalid);
  assign valid_post_o = (state_q == ifu_pkg::wait_ready);

  // capture on the r beat, advance pc on the handoff beat
  assign inst_we_o    = rvalid_i && rready_o;
  assign pc_we_o      = valid_post_o && ready_post_i;

  // ------------------------------------------------------------
  // state register
  // ------------------------------------------------------------

  always_ff @(posedge clock) begin
    if (reset) begin
      state_q <= ifu_pkg::idle;
    end else begin
      state_q <= state_d;
    end
  end

  // next state
  always_comb begin
    state_d = state_q;
    case (state_q)
      ifu_pkg::idle: begin
        if (start_i) state_d = ifu_pkg::wait_arready;
      end
      ifu_pkg::wait_arready: begin
        // address accepted, one read now in flight
        if (arready_i) state_d = ifu_pkg::wait_rvalid;
      end
      ifu_pkg::wait_rvalid: begin
        if (rvalid_i) state_d = ifu_pkg::wait_ready;
      end
      ifu_pkg::wait_ready: begin
        // jal parks until decode returns the target
        if (ready_post_i) begin
          state_d = branch_inst_i ? ifu_pkg::wait_branch : ifu_pkg::wait_arready;
        end
      end
      ifu_pkg::wait_branch: begin
        if (redirect_valid_i) state_d = ifu_pkg::wait_arready;
      end
      default: state_d = ifu_pkg::idle;
    endcase
  end

  // ------------------------------------------------------------
  // checks
  // ------------------------------------------------------------

  // never an address request while a read is still open
  a_ar_r_excl: assert property (@(posedge clock) disable iff (reset)
    !(arvalid_o && rready_o));

  // request held until accepted
  a_ar_hold: assert property (@(posedge clock) disable iff (reset)
    arvalid_o && !arready_i |=> arvalid_o);

endmodule

// ==== hw/ifu_pkg.sv ====
package ifu_pkg;

  // ------------------------------------------------------------
  // widths
  // ------------------------------------------------------------

  // byte address of one instruction word
  typedef logic [31:0] addr_t;
  // raw 32-bit instruction word
  typedef logic [31:0] inst_t;
  // major opcode, bits [6:0] of the word
  typedef logic [6:0]  opcode_t;

  // ------------------------------------------------------------
  // constants
  // ------------------------------------------------------------

  // jal major opcode
  localparam opcode_t OPC_JAL  = 7'b110_1111;
  // first fetch address out of reset
  localparam addr_t   RESET_PC = 32'h0000_0000;
  // sequential fetch stride in bytes
  localparam addr_t   PC_STEP  = 32'd4;

  // ------------------------------------------------------------
  // bundles
  // ------------------------------------------------------------

  // fetch -> decode handoff, also the retire payload
  typedef struct packed {
    addr_t pc;
    inst_t inst;
  } fetch_pkt_t;

  // decode -> fetch, valid is a single-cycle pulse
  typedef struct packed {
    logic  valid;
    addr_t target;
  } redirect_t;

  // fetch controller states
  typedef enum logic [2:0] {
    idle         = 3'd0,
    wait_arready = 3'd1,
    wait_rvalid  = 3'd2,
    wait_ready   = 3'd3,
    wait_branch  = 3'd4
  } fetch_state_t;

endpackage
